/* sources.f */
bitpack_pkg.sv
bitpack_fifo.sv
bitpack_packer.sv
bitpack_top.sv
tb_bitpack.sv

/* Makefile */
TOP := tb_bitpack

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		--top-module bitpack_top bitpack_pkg.sv bitpack_fifo.sv \
		bitpack_packer.sv bitpack_top.sv
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f sources.f

obj_dir/V$(TOP): sources.f bitpack_pkg.sv bitpack_fifo.sv bitpack_packer.sv \
		bitpack_top.sv tb_bitpack.sv
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f sources.f

sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

/* tb_bitpack.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_bitpack
   import bitpack_pkg::*;
();

   localparam int N_FULL      = 8;
   localparam int N_CONT      = 40;
   localparam int N_ALIGN     = 20;
   localparam int N_BP_FILL   = 64;  // upper bound, input fifo fills well before
   localparam int N_BP_MORE   = 24;
   localparam int N_SAMPLES   = N_FULL + N_CONT + N_ALIGN + N_BP_FILL + N_BP_MORE;
   localparam int WDOG_CYCLES = N_SAMPLES * 40 + 500;
   localparam int MAX_WORDS   = 128;

   logic                clk;
   logic                rst_n;
   pack_cfg_t           cfg;
   logic                in_push;
   logic [SAMPLE_W-1:0] in_data;
   logic                in_full;
   logic                flush;
   logic                out_valid;
   logic [WORD_W-1:0]   out_data;
   logic                out_pop;

   bit                  bits_q[$];  // model bitstream, msb first
   logic [WORD_W-1:0]   exp_words [MAX_WORDS];
   int                  exp_cnt = 0;
   int                  pop_idx = 0;
   int                  errors = 0;
   string               test_name;
   logic                push_done;

   bitpack_top u_bitpack_top (
      .clk_i       (clk),
      .rst_n_i     (rst_n),
      .cfg_i       (cfg),
      .in_push_i   (in_push),
      .in_data_i   (in_data),
      .in_full_o   (in_full),
      .flush_i     (flush),
      .out_valid_o (out_valid),
      .out_data_o  (out_data),
      .out_pop_i   (out_pop)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      if (out_pop) begin
         pop_idx <= pop_idx + 1;
      end
   end

   // every popped word must be the next one the model predicts
   a_word_match: assert property (@(posedge clk) disable iff (!rst_n)
      out_pop |-> (pop_idx < exp_cnt && out_data == exp_words[pop_idx]))
      else begin
         errors++;
         $display("mismatch %s word %0d expected %08h actual %08h", test_name,
                  $sampled(pop_idx), exp_words[$sampled(pop_idx)], $sampled(out_data));
      end

   function automatic void emit_word();
      logic [WORD_W-1:0] word;
      int                i;
      word = '0;
      for (i = 0; i < WORD_W; i++) begin
         word = {word[WORD_W-2:0], bits_q.pop_front()};
      end
      exp_words[exp_cnt] = word;
      exp_cnt++;
   endfunction

   function automatic void pad_word();
      while (bits_q.size() < WORD_W) begin
         bits_q.push_back(1'b0);
      end
      emit_word();
   endfunction

   function automatic void model_push(input logic [SAMPLE_W-1:0] d);
      int w;
      int i;
      w = int'(cfg.width);
      // aligned mode, a sample that does not fit opens a new word
      if (!cfg.wrap && bits_q.size() + w > WORD_W) begin
         pad_word();
      end
      for (i = w - 1; i >= 0; i--) begin
         bits_q.push_back(d[i]);
      end
      while (bits_q.size() >= WORD_W) begin
         emit_word();
      end
   endfunction

   task automatic push_sample(input logic [SAMPLE_W-1:0] d);
      while (in_full) begin
         @(negedge clk);
      end
      in_push = 1'b1;
      in_data = d;
      model_push(d);
      @(negedge clk);
      in_push = 1'b0;
   endtask

   // input fifo drained and packer parked
   task automatic wait_idle();
      while (u_bitpack_top.u_in_fifo.not_empty_o ||
             u_bitpack_top.u_packer.state_q != ST_IDLE) begin
         @(negedge clk);
      end
   endtask

   task automatic set_config(input int width, input bit wrap);
      wait_idle();
      cfg.width = WIDTH_W'(width);
      cfg.wrap  = wrap;
      @(negedge clk);
   endtask

   task automatic flush_packer();
      wait_idle();
      flush = 1'b1;
      if (bits_q.size() > 0) begin
         pad_word();
      end
      @(negedge clk);
      flush = 1'b0;
   endtask

   task automatic drain_words(input bit random_gaps);
      while (pop_idx < exp_cnt) begin
         out_pop = out_valid && (!random_gaps || $urandom_range(0, 1) == 1);
         @(negedge clk);
      end
      out_pop = 1'b0;
   endtask

   task automatic run_samples(input string name, input int width, input bit wrap,
                              input int count, input bit do_flush);
      int k;
      test_name = name;
      set_config(width, wrap);
      for (k = 0; k < count; k++) begin
         push_sample(SAMPLE_W'($urandom));
      end
      drain_words(1'b0);
      if (do_flush) begin
         flush_packer();
         drain_words(1'b0);
      end
   endtask

   task automatic run_back_pressure();
      int n;
      int k;
      test_name = "back_pressure";
      set_config(7, 1'b1);
      out_pop = 1'b0;
      n = 0;
      while (!in_full && n < N_BP_FILL) begin
         push_sample(SAMPLE_W'($urandom));
         n++;
      end
      a_bp_full: assert (in_full) else begin
         errors++;
         $display("input fifo did not fill while the output was blocked");
      end
      push_done = 1'b0;
      fork
         begin
            for (k = 0; k < N_BP_MORE; k++) begin
               push_sample(SAMPLE_W'($urandom));
            end
            push_done = 1'b1;
         end
         begin
            while (!push_done || pop_idx < exp_cnt) begin
               out_pop = out_valid && ($urandom_range(0, 1) == 1);
               @(negedge clk);
            end
            out_pop = 1'b0;
         end
      join
      flush_packer();
      drain_words(1'b1);
   endtask

   initial begin
      rst_n     = 1'b0;
      cfg.width = WIDTH_W'(16);
      cfg.wrap  = 1'b1;
      in_push   = 1'b0;
      in_data   = '0;
      flush     = 1'b0;
      out_pop   = 1'b0;
      push_done = 1'b0;
      test_name = "reset_state";
      void'($urandom(32'h73be));
      repeat (2) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      a_reset_state: assert (!out_valid && !in_full) else begin
         errors++;
         $display("mismatch %s expected valid 0 full 0 actual valid %b full %b",
                  test_name, out_valid, in_full);
      end

      run_samples("full_width", 16, 1'b1, N_FULL, 1'b0);
      run_samples("continuous", 5, 1'b1, N_CONT, 1'b1);
      run_samples("aligned", 5, 1'b0, N_ALIGN, 1'b1);
      run_back_pressure();

      test_name = "end_of_run";
      repeat (4) @(negedge clk);
      a_all_words: assert (pop_idx == exp_cnt && !out_valid) else begin
         errors++;
         $display("word count off, %0d expected, %0d popped, output fifo not empty %b",
                  exp_cnt, pop_idx, out_valid);
      end

      $display("%0d words checked, %0d errors", pop_idx, errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

   // bounded by the total sample count
   initial begin
      repeat (WDOG_CYCLES) @(posedge clk);
      $display("timeout, the run did not finish within %0d cycles in %s",
               WDOG_CYCLES, test_name);
      $display("%0d words checked, %0d errors, 1 timeout", pop_idx, errors);
      $display("Some tests failed");
      $finish;
   end

endmodule

`default_nettype wire

/* bitpack_top.sv */
`timescale 1ns/1ps
`default_nettype none

module bitpack_top
   import bitpack_pkg::*;
(
   input  wire                 clk_i,
   input  wire                 rst_n_i,

   input  wire pack_cfg_t      cfg_i,

   // sample input
   input  wire                 in_push_i,
   input  wire  [SAMPLE_W-1:0] in_data_i,
   output logic                in_full_o,

   input  wire                 flush_i,

   // word output
   output logic                out_valid_o,
   output logic [WORD_W-1:0]   out_data_o,
   input  wire                 out_pop_i
);

   logic [SAMPLE_W-1:0] in_head;
   logic                in_not_empty;
   logic                in_not_full;
   logic                pk_read;
   logic [WORD_W-1:0]   pk_wdata;
   logic                pk_write;
   logic                out_not_full;

   assign in_full_o = ~in_not_full;

   bitpack_fifo #(
      .DATA_W (SAMPLE_W)
   ) u_in_fifo (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .push_i      (in_push_i),
      .push_data_i (in_data_i),
      .pop_i       (pk_read),
      .pop_data_o  (in_head),
      .not_empty_o (in_not_empty),
      .not_full_o  (in_not_full)
   );

   bitpack_packer u_packer (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .cfg_i     (cfg_i),
      .flush_i   (flush_i),
      .r_data_i  (in_head),
      .r_ready_i (in_not_empty),
      .r_read_o  (pk_read),
      .w_data_o  (pk_wdata),
      .w_write_o (pk_write),
      .w_ready_i (out_not_full)
   );

   bitpack_fifo #(
      .DATA_W (WORD_W)
   ) u_out_fifo (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .push_i      (pk_write),
      .push_data_i (pk_wdata),
      .pop_i       (out_pop_i),
      .pop_data_o  (out_data_o),
      .not_empty_o (out_valid_o),
      .not_full_o  (out_not_full)
   );

endmodule

`default_nettype wire

/* bitpack_packer.sv */
`timescale 1ns/1ps
`default_nettype none

module bitpack_packer
   import bitpack_pkg::*;
(
   input  wire                 clk_i,
   input  wire                 rst_n_i,

   input  wire pack_cfg_t      cfg_i,
   input  wire                 flush_i,

   // sample side fed from the input fifo head
   input  wire  [SAMPLE_W-1:0] r_data_i,
   input  wire                 r_ready_i,
   output logic                r_read_o,

   // word side into the output fifo
   output logic [WORD_W-1:0]   w_data_o,
   output logic                w_write_o,
   input  wire                 w_ready_i
);

   pack_state_e         state_q;
   pack_state_e         state_d;
   logic [CNT_W-1:0]    cnt_q;     // valid bits held in the low end of sr_q
   logic [CNT_W-1:0]    cnt_d;
   logic [SR_W-1:0]     sr_q;
   logic [SR_W-1:0]     sr_d;

   logic [SAMPLE_W-1:0] sample;
   logic [SR_W-1:0]     sr_shifted;
   logic [CNT_W-1:0]    cnt_sum;
   logic                full_word;

   // drop bits above the configured width
   assign sample = r_data_i & ~({SAMPLE_W{1'b1}} << cfg_i.width);

   // accumulator and shifter
   assign sr_shifted = (sr_q << cfg_i.width) | SR_W'(sample);
   assign cnt_sum    = cnt_q + CNT_W'(cfg_i.width);
   assign full_word  = (cnt_q >= CNT_W'(WORD_W));

   // full word takes the top WORD_W valid bits and leaves the excess below
   // partial word is left justified with zero fill
   always_comb begin
      if (full_word) begin
         w_data_o = WORD_W'(sr_q >> (cnt_q - CNT_W'(WORD_W)));
      end else begin
         w_data_o = WORD_W'(sr_q << (CNT_W'(WORD_W) - cnt_q));
      end
   end

   always_comb begin
      state_d   = state_q;
      cnt_d     = cnt_q;
      sr_d      = sr_q;
      r_read_o  = 1'b0;
      w_write_o = 1'b0;

      case (state_q)
         ST_IDLE: begin
            if (flush_i && cnt_q != '0) begin
               state_d = ST_EMIT;  // partial word
            end else if (r_ready_i) begin
               state_d = ST_LOAD;
            end
         end

         ST_LOAD: begin
            if (!r_ready_i) begin
               state_d = ST_IDLE;
            end else if (cnt_sum < CNT_W'(WORD_W)) begin
               r_read_o = 1'b1;
               sr_d     = sr_shifted;
               cnt_d    = cnt_sum;
            end else if (cfg_i.wrap || cnt_sum == CNT_W'(WORD_W)) begin
               // word completes and any excess carries over
               r_read_o = 1'b1;
               sr_d     = sr_shifted;
               cnt_d    = cnt_sum;
               state_d  = ST_EMIT;
            end else begin
               // no room in aligned mode so the sample stays at the fifo head
               state_d = ST_EMIT;
            end
         end

         ST_EMIT: begin
            if (w_ready_i) begin
               w_write_o = 1'b1;
               cnt_d     = full_word ? cnt_q - CNT_W'(WORD_W) : '0;
               state_d   = r_ready_i ? ST_LOAD : ST_IDLE;
            end
         end

         default: begin
            state_d = ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q <= ST_IDLE;
         cnt_q   <= '0;
         sr_q    <= '0;
      end else begin
         state_q <= state_d;
         cnt_q   <= cnt_d;
         sr_q    <= sr_d;
      end
   end

   // width must be legal whenever a sample is taken
   a_width_legal: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      r_read_o |-> (cfg_i.width != '0 && cfg_i.width <= WIDTH_W'(SAMPLE_W)))
      else $error("bitpack_packer: sample width %0d out of range", cfg_i.width);

   // config may only move while idle
   a_cfg_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (state_q != ST_IDLE) |-> $stable(cfg_i))
      else $error("bitpack_packer: cfg changed while busy");

endmodule

`default_nettype wire

/* bitpack_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module bitpack_fifo
   import bitpack_pkg::*;
#(
   parameter int DATA_W = SAMPLE_W
) (
   input  wire               clk_i,
   input  wire               rst_n_i,

   input  wire               push_i,
   input  wire  [DATA_W-1:0] push_data_i,
   input  wire               pop_i,

   output logic [DATA_W-1:0] pop_data_o,
   output logic              not_empty_o,
   output logic              not_full_o
);

   logic [DATA_W-1:0]     mem [FIFO_DEPTH];
   logic [FIFO_AW-1:0]    wr_ptr_q;
   logic [FIFO_AW-1:0]    rd_ptr_q;
   logic [FIFO_CNT_W-1:0] count_q;
   logic                  do_push;
   logic                  do_pop;

   assign not_empty_o = (count_q != '0);
   assign not_full_o  = (count_q != FIFO_CNT_W'(FIFO_DEPTH));

   assign do_push = push_i & not_full_o;
   assign do_pop  = pop_i & not_empty_o;

   // first word fall through
   assign pop_data_o = mem[rd_ptr_q];

   always_ff @(posedge clk_i) begin
      if (do_push) begin
         mem[wr_ptr_q] <= push_data_i;
      end
   end

   // pointers wrap naturally, depth is a power of two
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (do_pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;  // none, or push and pop together
         endcase
      end
   end

   // caller must respect the level outputs
   a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      push_i |-> not_full_o)
      else $error("bitpack_fifo: push while full");

   a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      pop_i |-> not_empty_o)
      else $error("bitpack_fifo: pop while empty");

endmodule

`default_nettype wire

/* bitpack_pkg.sv */
`default_nettype none

package bitpack_pkg;

   // sample and word sizes
   localparam int SAMPLE_W = 16;
   localparam int WORD_W   = 32;
   localparam int SR_W     = 2 * WORD_W;  // shift register, room for a word plus overflow

   localparam int CNT_W    = 6;   // bit count, holds up to WORD_W + SAMPLE_W - 1
   localparam int WIDTH_W  = 5;   // sample width field, 1..16

   // fifo geometry
   localparam int FIFO_DEPTH = 8;
   localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
   localparam int FIFO_CNT_W = FIFO_AW + 1;  // occupancy 0..FIFO_DEPTH

   // packer program counter
   typedef enum logic [1:0] {
      ST_IDLE = 2'd0,
      ST_LOAD = 2'd1,
      ST_EMIT = 2'd2
   } pack_state_e;

   // packer configuration, only changed while idle
   typedef struct packed {
      logic [WIDTH_W-1:0] width;  // bits per sample
      logic               wrap;   // 1 continuous, 0 aligned
   } pack_cfg_t;

endpackage

`default_nettype wire
